/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ecc_mem_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+src
src/ecc_pkg.sv
src/ecc_req_queue.sv
src/ecc_store.sv
src/ecc_decode.sv
src/ecc_mem_top.sv
verification/ecc_mem_tb.sv

/* src/ecc_decode.sv */
// corrects one flipped bit and flags two; three or more flips can be miscorrected
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_decode
   import ecc_pkg::*;
(
   input  logic      clk,
   input  logic      rst_l,
   input  logic      rd_valid,
   input  ecc_rd_t   rd,
   output logic      resp_valid,
   output ecc_resp_t resp
);

   localparam int SYN_W = `ECC_CHECK_W - 1;

   logic [SYN_W-1:0] syn;
   logic             par;       // odd count of flips seen
   logic [SYN_W-1:0] err_pos;
   ecc_word_t        emask;
   ecc_status_e      status;
   logic [`ECC_DATA_W-1:0] data;

   // stored checks xor recomputed checks, taken in one pass over positions 1..71
   always_comb begin
      syn = '0;
      for (int k = 0; k < SYN_W; k++) begin
         for (int p = 1; p < `ECC_WORD_W; p++) begin
            if (((p >> k) & 1) == 1)
               syn[k] = syn[k] ^ rd.word[p-1];
         end
      end
   end

   assign par = ^rd.word;

   // zero syndrome with bad parity means the parity bit itself flipped
   assign err_pos = (syn == '0) ? SYN_W'(`ECC_WORD_W) : syn;

   always_comb begin
      emask = '0;
      for (int p = 1; p <= `ECC_WORD_W; p++) begin
         if (par && (err_pos == SYN_W'(p)))
            emask[p-1] = 1'b1;
      end
   end

   // even flip count with a nonzero syndrome is flagged, data left as stored
   assign status = ecc_status_e'(par ? ECC_CORRECTED :
                                 (syn != '0) ? ECC_UNCORRECTABLE : ECC_OK);

   assign data = ecc_extract_data(rd.word ^ emask);

   always_ff @(posedge clk) begin
      if (rd_valid) begin
         resp.addr   <= rd.addr;
         resp.data   <= data;
         resp.status <= status;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_l)
         resp_valid <= 1'b0;
      else
         resp_valid <= rd_valid;
   end

   // catches a read of an address that was never written
   a_status_known: assert property (@(posedge clk) disable iff (!rst_l)
      resp_valid |-> !$isunknown(resp.status))
      else $error("response status unknown, address likely never written");

endmodule

/* src/ecc_defs.svh */
// sizes for the 64-bit SECDED store; the layout helpers assume 7 Hamming bits plus overall parity
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// data word and codeword widths
`define ECC_DATA_W 64
`define ECC_CHECK_W 8   // c0..c6 plus overall parity
`define ECC_WORD_W 72

// storage array is 2**ECC_ADDR_W words
`define ECC_ADDR_W 4

// request FIFO depth, also the sender's starting credit count
`define ECC_QDEPTH 4

// response slots the receiver grants at reset
`define ECC_RESP_CREDITS 2

`endif

/* src/ecc_mem_top.sv */
// request and response sides both use pulse credits; a read answers two cycles after it pops
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_mem_top
   import ecc_pkg::*;
(
   input  logic      clk,
   input  logic      rst_l,
   input  logic      req_valid,
   input  ecc_req_t  req,
   output logic      req_credit,
   output logic      resp_valid,
   output ecc_resp_t resp,
   input  logic      resp_credit
);

   logic                   wr_en;
   ecc_req_t               wr_req;
   logic                   rd_en;
   logic [`ECC_ADDR_W-1:0] rd_addr;
   logic                   rd_valid;
   ecc_rd_t                rd;

   // FIFO and credit control
   ecc_req_queue u_queue (
      .clk         (clk),
      .rst_l       (rst_l),
      .req_valid   (req_valid),
      .req         (req),
      .resp_credit (resp_credit),
      .req_credit  (req_credit),
      .wr_en       (wr_en),
      .wr_req      (wr_req),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr)
   );

   // encode and array
   ecc_store u_store (
      .clk      (clk),
      .rst_l    (rst_l),
      .wr_en    (wr_en),
      .wr_req   (wr_req),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_valid (rd_valid),
      .rd       (rd)
   );

   ecc_decode u_decode (
      .clk        (clk),
      .rst_l      (rst_l),
      .rd_valid   (rd_valid),
      .rd         (rd),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

/* src/ecc_pkg.sv */
// codeword positions are 1-based: checks at powers of two, data fills the rest, parity at 72
package ecc_pkg;
   `include "ecc_defs.svh"

   typedef enum logic {
      OP_WRITE = 1'b0,
      OP_READ  = 1'b1
   } ecc_op_e;

   typedef enum logic [1:0] {
      ECC_OK            = 2'd0,
      ECC_CORRECTED     = 2'd1,
      ECC_UNCORRECTABLE = 2'd2
   } ecc_status_e;

   typedef logic [`ECC_WORD_W-1:0] ecc_word_t;

   typedef struct packed {
      ecc_op_e                 op;
      logic [`ECC_ADDR_W-1:0]  addr;
      logic [`ECC_DATA_W-1:0]  wdata;
      ecc_word_t               flip;   // xor'd into the codeword on writes
   } ecc_req_t;

   typedef struct packed {
      logic [`ECC_ADDR_W-1:0]  addr;
      ecc_word_t               word;
   } ecc_rd_t;

   typedef struct packed {
      logic [`ECC_ADDR_W-1:0]  addr;
      logic [`ECC_DATA_W-1:0]  data;
      ecc_status_e             status;
   } ecc_resp_t;

   // scatter data bits into the non power-of-two positions, check slots left zero
   function automatic ecc_word_t ecc_place_data(input logic [`ECC_DATA_W-1:0] data);
      ecc_word_t w;
      int        j;
      w = '0;
      j = 0;
      for (int p = 1; p < `ECC_WORD_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            w[p-1] = data[j];
            j++;
         end
      end
      return w;
   endfunction

   // gather the data bits back out of a codeword
   function automatic logic [`ECC_DATA_W-1:0] ecc_extract_data(input ecc_word_t w);
      logic [`ECC_DATA_W-1:0] data;
      int                     j;
      data = '0;
      j = 0;
      for (int p = 1; p < `ECC_WORD_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            data[j] = w[p-1];
            j++;
         end
      end
      return data;
   endfunction

endpackage

/* src/ecc_req_queue.sv */
// sender must hold a credit per request; reads pop only with a response credit in hand
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_req_queue
   import ecc_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   req_valid,
   input  ecc_req_t               req,
   input  logic                   resp_credit,
   output logic                   req_credit,
   output logic                   wr_en,
   output ecc_req_t               wr_req,
   output logic                   rd_en,
   output logic [`ECC_ADDR_W-1:0] rd_addr
);

   localparam int PTR_W  = $clog2(`ECC_QDEPTH);
   localparam int CNT_W  = $clog2(`ECC_QDEPTH + 1);
   localparam int CRED_W = $clog2(`ECC_RESP_CREDITS + 1);

   ecc_req_t          fifo [0:`ECC_QDEPTH-1];
   logic [PTR_W-1:0]  wptr;
   logic [PTR_W-1:0]  rptr;
   logic [CNT_W-1:0]  count;
   logic [CRED_W-1:0] resp_cred;   // response slots still free downstream
   ecc_req_t          head;
   logic              head_rd;
   logic              pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`ECC_QDEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign head    = fifo[rptr];
   assign head_rd = (head.op == OP_READ);

   // writes always go, a read needs a response slot
   assign pop = (count != '0) && (!head_rd || (resp_cred != '0));

   assign req_credit = pop;   // slot freed as the head leaves
   assign wr_en      = pop && !head_rd;
   assign rd_en      = pop && head_rd;
   assign wr_req     = head;
   assign rd_addr    = head.addr;

   always_ff @(posedge clk) begin
      if (req_valid) begin
         fifo[wptr] <= req;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_l) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (req_valid)
            wptr <= next_ptr(wptr);
         if (pop)
            rptr <= next_ptr(rptr);
         case ({req_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_l)
         resp_cred <= CRED_W'(`ECC_RESP_CREDITS);
      else if (rd_en && !resp_credit)
         resp_cred <= resp_cred - 1'b1;
      else if (!rd_en && resp_credit)
         resp_cred <= resp_cred + 1'b1;
   end

   // a full FIFO may only take a request on the edge its head leaves
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_l)
      req_valid |-> ((count < CNT_W'(`ECC_QDEPTH)) || pop))
      else $error("request arrived with the FIFO full");

   // receiver returned more slots than it was ever given
   a_cred_bound: assert property (@(posedge clk) disable iff (!rst_l)
      resp_cred <= CRED_W'(`ECC_RESP_CREDITS))
      else $error("response credit count above its initial value");

endmodule

/* src/ecc_store.sv */
// array has no reset and reads back X until written; one access per cycle
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_store
   import ecc_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   wr_en,
   input  ecc_req_t               wr_req,
   input  logic                   rd_en,
   input  logic [`ECC_ADDR_W-1:0] rd_addr,
   output logic                   rd_valid,
   output ecc_rd_t                rd
);

   localparam int HAM_W = `ECC_CHECK_W - 1;   // check bits without overall parity

   ecc_word_t mem [0:(1<<`ECC_ADDR_W)-1];
   ecc_word_t placed;
   ecc_word_t enc;

   assign placed = ecc_place_data(wr_req.wdata);

   // ck covers every position with bit k set
   always_comb begin
      logic c;
      enc = placed;
      for (int k = 0; k < HAM_W; k++) begin
         c = 1'b0;
         for (int p = 1; p < `ECC_WORD_W; p++) begin
            if (((p >> k) & 1) == 1)
               c = c ^ placed[p-1];
         end
         enc[(1 << k) - 1] = c;
      end
      enc[`ECC_WORD_W-1] = ^enc[`ECC_WORD_W-2:0];   // overall parity over 1..71
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_req.addr] <= enc ^ wr_req.flip;   // injected errors land in the array
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd.addr <= rd_addr;
         rd.word <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_l)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

   // the queue issues one head per cycle, so the ports never collide
   a_one_access: assert property (@(posedge clk) disable iff (!rst_l)
      !(wr_en && rd_en))
      else $error("write and read issued in the same cycle");

endmodule

/* verification/ecc_mem_tb.sv */
// needs 4-deep request FIFO and 2 response credits from ecc_defs.svh; every read targets a written address
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_mem_tb import ecc_pkg::*; ();

   localparam int N_SINGLE = 12;
   localparam int N_DOUBLE = 12;
   localparam int N_HOLD   = 6;
   localparam int N_REQ    = 2 * 16 + 2 * N_SINGLE + 2 * N_DOUBLE + N_HOLD;
   localparam int LIMIT    = N_REQ * 200 + 20;   // cycles, reset included

   logic      clk;
   logic      rst_l;
   logic      req_valid;
   ecc_req_t  req;
   logic      req_credit;
   logic      resp_valid;
   ecc_resp_t resp;
   logic      resp_credit;

   logic [31:0]            lcg_state = 32'd80;
   logic [`ECC_DATA_W-1:0] shadow_data [0:(1<<`ECC_ADDR_W)-1];
   ecc_word_t              shadow_flip [0:(1<<`ECC_ADDR_W)-1];
   ecc_resp_t              exp_q [$];
   string                  name_q [$];
   ecc_resp_t              exp_r;
   string                  exp_name;
   int sent          = 0;
   int credit_pulses = 0;   // req_credit pulses seen so far
   int resp_count    = 0;
   int owed          = 0;   // response slots not yet handed back
   int resp_at_hold;
   logic hold_credits = 1'b0;

   ecc_mem_top DUT (
      .clk         (clk),
      .rst_l       (rst_l),
      .req_valid   (req_valid),
      .req         (req),
      .req_credit  (req_credit),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .resp_credit (resp_credit)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic rand32(output logic [31:0] r);
      lcg_state = lcg_next(lcg_state);
      r = lcg_state;
   endtask

   // encode, apply the flip mask, then decode, all by position number
   function automatic ecc_resp_t ref_resp(input logic [`ECC_ADDR_W-1:0] addr,
                                          input logic [`ECC_DATA_W-1:0] data,
                                          input ecc_word_t flip);
      logic [`ECC_WORD_W:1] cw;   // indexed by 1-based position
      logic [6:0]           s;
      logic                 p;
      int                   pos;
      int                   fix;
      ecc_resp_t            r;
      cw  = '0;
      pos = 1;
      for (int j = 0; j < `ECC_DATA_W; j++) begin
         pos++;
         while ((pos & (pos - 1)) == 0)
            pos++;
         cw[pos] = data[j];
      end
      for (int k = 0; k < 7; k++) begin
         for (int q = 3; q < `ECC_WORD_W; q++) begin
            if (((q & (q - 1)) != 0) && (((q >> k) & 1) == 1))
               cw[1 << k] = cw[1 << k] ^ cw[q];
         end
      end
      cw[`ECC_WORD_W] = ^cw[`ECC_WORD_W-1:1];
      cw = cw ^ flip;
      s = '0;
      for (int q = 1; q < `ECC_WORD_W; q++) begin
         if (cw[q])
            s = s ^ 7'(q);   // syndrome is the xor of set positions
      end
      p = ^cw;
      r.addr = addr;
      if (p) begin
         fix = (s == '0) ? `ECC_WORD_W : int'(s);
         if (fix <= `ECC_WORD_W)
            cw[fix] = ~cw[fix];
         r.status = ECC_CORRECTED;
      end else if (s != '0) begin
         r.status = ECC_UNCORRECTABLE;
      end else begin
         r.status = ECC_OK;
      end
      pos = 1;
      for (int j = 0; j < `ECC_DATA_W; j++) begin
         pos++;
         while ((pos & (pos - 1)) == 0)
            pos++;
         r.data[j] = cw[pos];
      end
      return r;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_data(input string name, input logic [`ECC_DATA_W-1:0] exp,
                             input logic [`ECC_DATA_W-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s data: expected %h, actual %h",
                                 name, exp, act));
   endtask

   task automatic check_status(input string name, input ecc_status_e exp,
                               input ecc_status_e act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s status: expected %s, actual %s (%0d)",
                                 name, exp.name(), act.name(), act));
   endtask

   task automatic check_addr(input string name, input logic [`ECC_ADDR_W-1:0] exp,
                             input logic [`ECC_ADDR_W-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s addr: expected %h, actual %h",
                                 name, exp, act));
   endtask

   // sender side of the request credits
   task automatic send_req(input ecc_req_t r, input string name);
      @(negedge clk);
      req_valid = 1'b0;
      while (sent - credit_pulses >= `ECC_QDEPTH)
         @(negedge clk);
      if (r.op == OP_READ) begin
         exp_q.push_back(ref_resp(r.addr, shadow_data[r.addr], shadow_flip[r.addr]));
         name_q.push_back(name);
      end else begin
         shadow_data[r.addr] = r.wdata;
         shadow_flip[r.addr] = r.flip;
      end
      req       = r;
      req_valid = 1'b1;
      sent++;
   endtask

   task automatic do_write(input logic [`ECC_ADDR_W-1:0] a, input logic [`ECC_DATA_W-1:0] d,
                           input ecc_word_t f, input string name);
      send_req('{op: OP_WRITE, addr: a, wdata: d, flip: f}, name);
   endtask

   task automatic do_read(input logic [`ECC_ADDR_W-1:0] a, input string name);
      send_req('{op: OP_READ, addr: a, wdata: '0, flip: '0}, name);
   endtask

   task automatic end_burst();
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || owed != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   always @(posedge clk) begin
      if (rst_l && req_credit)
         credit_pulses++;
   end

   // hands back response slots and compares each response in order
   initial begin
      resp_credit = 1'b0;
      forever begin
         @(negedge clk);
         if (owed > 0 && !hold_credits) begin
            resp_credit = 1'b1;
            owed--;
         end else begin
            resp_credit = 1'b0;
         end
         if (rst_l && resp_valid) begin
            if (exp_q.size() == 0)
               stop_on_error("a response arrived when no read was outstanding");
            exp_r    = exp_q.pop_front();
            exp_name = name_q.pop_front();
            check_addr(exp_name, exp_r.addr, resp.addr);
            check_data(exp_name, exp_r.data, resp.data);
            check_status(exp_name, exp_r.status, resp.status);
            owed++;
            resp_count++;
         end
      end
   end

   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("timeout: the DUT stopped answering before all %0d requests were served", N_REQ);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0]            r1;
      logic [31:0]            r2;
      logic [`ECC_ADDR_W-1:0] a;
      ecc_word_t              f;
      int                     p1;
      int                     p2;
      rst_l     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_l = 1'b1;

      repeat (5) begin
         @(negedge clk);
         if (resp_valid !== 1'b0)
            stop_on_error("resp_valid went high after reset with no request sent");
         if (req_credit !== 1'b0)
            stop_on_error("req_credit pulsed after reset with no request sent");
      end

      for (int i = 0; i < 16; i++) begin
         rand32(r1);
         rand32(r2);
         do_write(`ECC_ADDR_W'(i), {r1, r2}, '0, "clean");
      end
      for (int i = 0; i < 16; i++)
         do_read(`ECC_ADDR_W'(i), $sformatf("clean_%0d", i));

      for (int i = 0; i < N_SINGLE; i++) begin
         rand32(r1);
         a = r1[27:24];
         rand32(r1);
         rand32(r2);
         p1 = (i == 0) ? `ECC_WORD_W - 1 : int'(r2[31:16]) % `ECC_WORD_W;   // parity bit first
         f = '0;
         f[p1] = 1'b1;
         do_write(a, {r1, r2}, f, "single_flip");
         do_read(a, $sformatf("single_flip_%0d", i));
      end

      for (int i = 0; i < N_DOUBLE; i++) begin
         rand32(r1);
         a = r1[27:24];
         rand32(r1);
         rand32(r2);
         p1 = int'(r1[31:16]) % `ECC_WORD_W;
         p2 = (p1 + 1 + int'(r2[31:16]) % (`ECC_WORD_W - 1)) % `ECC_WORD_W;
         f = '0;
         f[p1] = 1'b1;
         f[p2] = 1'b1;
         do_write(a, {r1, r2}, f, "double_flip");
         do_read(a, $sformatf("double_flip_%0d", i));
      end
      end_burst();
      wait_drain();

      // withhold response slots while reads pile up
      hold_credits = 1'b1;
      resp_at_hold = resp_count;
      for (int i = 0; i < N_HOLD; i++)
         do_read(`ECC_ADDR_W'(i * 3), $sformatf("backpressure_%0d", i));
      end_burst();
      repeat (20) @(posedge clk);
      if (resp_count - resp_at_hold > `ECC_RESP_CREDITS)
         stop_on_error($sformatf("CHECK FAILED backpressure responses: expected at most %0d, actual %0d",
                                 `ECC_RESP_CREDITS, resp_count - resp_at_hold));
      hold_credits = 1'b0;
      wait_drain();

      if (credit_pulses != sent) begin
         stop_on_error($sformatf("CHECK FAILED req_credit_count: expected %0d, actual %0d",
                                 sent, credit_pulses));
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule
